// File: verilog/rv_pkg.sv
package rv_pkg;

    localparam int unsigned XLEN   = 32;
    localparam int unsigned REG_AW = 5;
    localparam int unsigned MEM_AW = 8;   // 256 words

    // major opcodes
    localparam logic [6:0] OP_RTYPE = 7'b0110011;
    localparam logic [6:0] OP_ITYPE = 7'b0010011;
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_LW_SW   = 3'b010;

    localparam logic [6:0] F7_SUB = 7'b0100000;

    // request fsm states, shared by executor and debug port
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_REQ  = 2'd1;
    localparam logic [1:0] ST_WAIT = 2'd2;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
    } instr_u;

endpackage

// File: verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [rv_pkg::REG_AW-1:0] raddr1_i,
    input  logic [rv_pkg::REG_AW-1:0] raddr2_i,
    input  logic [rv_pkg::REG_AW-1:0] bus_raddr_i,
    output logic [rv_pkg::XLEN-1:0]   rdata1_o,
    output logic [rv_pkg::XLEN-1:0]   rdata2_o,
    output logic [rv_pkg::XLEN-1:0]   bus_data_o,
    input  logic                      we_i,
    input  logic [rv_pkg::REG_AW-1:0] waddr_i,
    input  logic [rv_pkg::XLEN-1:0]   wdata_i
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [2**REG_AW];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin   // x0 stays zero
            regs[waddr_i] <= wdata_i;
        end
    end

    // core read ports
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

    // debug bus read port
    assign bus_data_o = (bus_raddr_i == '0) ? '0 : regs[bus_raddr_i];

    // writeback data must be clean whenever a write is requested
    a_wdata_known: assert property (
        @(posedge clk) disable iff (!rst_n) we_i |-> !$isunknown(wdata_i)
    ) else $error("reg_file write with unknown data");

endmodule

// File: verilog/inst_exec.sv
`timescale 1ns/1ps

module inst_exec (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      instr_valid_i,
    input  rv_pkg::instr_u            instr_i,
    output logic                      busy_o,
    output logic [rv_pkg::REG_AW-1:0] rs1_addr_o,
    output logic [rv_pkg::REG_AW-1:0] rs2_addr_o,
    input  logic [rv_pkg::XLEN-1:0]   rs1_data_i,
    input  logic [rv_pkg::XLEN-1:0]   rs2_data_i,
    output logic                      rd_we_o,
    output logic [rv_pkg::REG_AW-1:0] rd_addr_o,
    output logic [rv_pkg::XLEN-1:0]   rd_data_o,
    output logic                      mem_req_o,
    output logic                      mem_we_o,
    output logic [rv_pkg::MEM_AW-1:0] mem_addr_o,
    output logic [rv_pkg::XLEN-1:0]   mem_wdata_o,
    input  logic                      mem_gnt_i,
    input  logic [rv_pkg::XLEN-1:0]   mem_rdata_i
);
    import rv_pkg::*;

    logic [1:0]        state_q;
    logic              accept;
    logic              alu_ok;
    logic              is_load;
    logic              is_store;
    logic [XLEN-1:0]   imm_i_ext;
    logic [XLEN-1:0]   imm_s_ext;
    logic [XLEN-1:0]   alu_res;
    logic [XLEN-1:0]   ls_addr;
    logic              mem_we_q;
    logic [MEM_AW-1:0] addr_q;
    logic [XLEN-1:0]   wdata_q;
    logic [REG_AW-1:0] ld_rd_q;

    assign accept = instr_valid_i && (state_q == ST_IDLE);

    // rs1/rs2 sit at the same bits in every format
    assign rs1_addr_o = instr_i.r.rs1;
    assign rs2_addr_o = instr_i.r.rs2;

    assign imm_i_ext = {{(XLEN-12){instr_i.i.imm[11]}}, instr_i.i.imm};
    assign imm_s_ext = {{(XLEN-12){instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};

    assign is_load  = (instr_i.i.opcode == OP_LOAD) && (instr_i.i.funct3 == F3_LW_SW);
    assign is_store = (instr_i.s.opcode == OP_STORE) && (instr_i.s.funct3 == F3_LW_SW);

    always_comb begin
        alu_ok  = 1'b0;
        alu_res = '0;
        case (instr_i.r.opcode)
            OP_RTYPE: begin
                if (instr_i.r.funct7 == '0) begin
                    alu_ok = 1'b1;
                    case (instr_i.r.funct3)
                        F3_ADD_SUB: alu_res = rs1_data_i + rs2_data_i;
                        F3_XOR:     alu_res = rs1_data_i ^ rs2_data_i;
                        F3_OR:      alu_res = rs1_data_i | rs2_data_i;
                        F3_AND:     alu_res = rs1_data_i & rs2_data_i;
                        default:    alu_ok  = 1'b0;   // unsupported, no-op
                    endcase
                end else if (instr_i.r.funct7 == F7_SUB && instr_i.r.funct3 == F3_ADD_SUB) begin
                    alu_ok  = 1'b1;
                    alu_res = rs1_data_i - rs2_data_i;
                end
            end
            OP_ITYPE: begin
                if (instr_i.i.funct3 == F3_ADD_SUB) begin   // addi only
                    alu_ok  = 1'b1;
                    alu_res = rs1_data_i + imm_i_ext;
                end
            end
            default: begin
                alu_ok = 1'b0;
            end
        endcase
    end

    // byte address, word index taken below
    assign ls_addr = rs1_data_i + (is_store ? imm_s_ext : imm_i_ext);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= ST_IDLE;
            mem_we_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (accept && (is_load || is_store)) begin
                        state_q  <= ST_REQ;
                        mem_we_q <= is_store;
                    end
                end
                ST_REQ: begin
                    if (mem_gnt_i) begin
                        state_q <= mem_we_q ? ST_IDLE : ST_WAIT;
                    end
                end
                ST_WAIT: state_q <= ST_IDLE;   // load data written back here
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= ls_addr[MEM_AW+1:2];
            wdata_q <= rs2_data_i;
            ld_rd_q <= instr_i.i.rd;
        end
    end

    assign busy_o      = (state_q != ST_IDLE);
    assign mem_req_o   = (state_q == ST_REQ);
    assign mem_we_o    = mem_we_q;
    assign mem_addr_o  = addr_q;
    assign mem_wdata_o = wdata_q;

    // alu results go back on the accepting edge, load data one cycle after grant
    assign rd_we_o   = (accept && alu_ok) || (state_q == ST_WAIT);
    assign rd_addr_o = (state_q == ST_WAIT) ? ld_rd_q : instr_i.r.rd;
    assign rd_data_o = (state_q == ST_WAIT) ? mem_rdata_i : alu_res;

    a_no_issue_when_busy: assert property (
        @(posedge clk) disable iff (!rst_n) busy_o |-> !instr_valid_i
    ) else $error("instruction issued while executor busy");

endmodule

// File: verilog/debug_port.sv
`timescale 1ns/1ps

module debug_port (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      dbg_req_i,
    input  logic                      dbg_mem_i,
    input  logic                      dbg_we_i,
    input  logic [rv_pkg::MEM_AW-1:0] dbg_addr_i,
    input  logic [rv_pkg::XLEN-1:0]   dbg_wdata_i,
    output logic                      dbg_ack_o,
    output logic [rv_pkg::XLEN-1:0]   dbg_rdata_o,
    output logic [rv_pkg::REG_AW-1:0] reg_addr_o,
    input  logic [rv_pkg::XLEN-1:0]   reg_data_i,
    output logic                      mem_req_o,
    output logic                      mem_we_o,
    output logic [rv_pkg::MEM_AW-1:0] mem_addr_o,
    output logic [rv_pkg::XLEN-1:0]   mem_wdata_o,
    input  logic                      mem_gnt_i,
    input  logic [rv_pkg::XLEN-1:0]   mem_rdata_i
);
    import rv_pkg::*;

    logic [1:0]        state_q;
    logic              accept;
    logic              mem_we_q;
    logic [MEM_AW-1:0] addr_q;
    logic [XLEN-1:0]   wdata_q;

    // requests while one is in flight are dropped
    assign accept     = dbg_req_i && (state_q == ST_IDLE) && !dbg_ack_o;
    assign reg_addr_o = dbg_addr_i[REG_AW-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= ST_IDLE;
            mem_we_q  <= 1'b0;
            dbg_ack_o <= 1'b0;
        end else begin
            dbg_ack_o <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (accept && dbg_mem_i) begin
                        state_q  <= ST_REQ;
                        mem_we_q <= dbg_we_i;
                    end else if (accept) begin
                        dbg_ack_o <= 1'b1;   // register read, one cycle
                    end
                end
                ST_REQ: begin
                    if (mem_gnt_i && mem_we_q) begin
                        state_q   <= ST_IDLE;
                        dbg_ack_o <= 1'b1;
                    end else if (mem_gnt_i) begin
                        state_q <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    state_q   <= ST_IDLE;
                    dbg_ack_o <= 1'b1;
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= dbg_addr_i;
            wdata_q <= dbg_wdata_i;
        end
        if (accept && !dbg_mem_i) begin
            dbg_rdata_o <= reg_data_i;
        end else if (state_q == ST_WAIT) begin
            dbg_rdata_o <= mem_rdata_i;   // ram output valid now
        end
    end

    assign mem_req_o   = (state_q == ST_REQ);
    assign mem_we_o    = mem_we_q;
    assign mem_addr_o  = addr_q;
    assign mem_wdata_o = wdata_q;

    a_gnt_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n) mem_gnt_i |-> mem_req_o
    ) else $error("ram grant without a debug request");

endmodule

// File: verilog/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      core_req_i,
    input  logic                      core_we_i,
    input  logic [rv_pkg::MEM_AW-1:0] core_addr_i,
    input  logic [rv_pkg::XLEN-1:0]   core_wdata_i,
    input  logic                      dbg_req_i,
    input  logic                      dbg_we_i,
    input  logic [rv_pkg::MEM_AW-1:0] dbg_addr_i,
    input  logic [rv_pkg::XLEN-1:0]   dbg_wdata_i,
    output logic                      core_gnt_o,
    output logic                      dbg_gnt_o,
    output logic                      ram_we_o,
    output logic [rv_pkg::MEM_AW-1:0] ram_addr_o,
    output logic [rv_pkg::XLEN-1:0]   ram_wdata_o
);

    logic last_dbg_q;   // debug port won the last grant

    always_comb begin
        core_gnt_o = core_req_i;
        dbg_gnt_o  = dbg_req_i;
        if (core_req_i && dbg_req_i) begin
            core_gnt_o = last_dbg_q;
            dbg_gnt_o  = !last_dbg_q;
        end
    end

    always_comb begin
        ram_we_o    = 1'b0;
        ram_addr_o  = core_addr_i;
        ram_wdata_o = core_wdata_i;
        if (core_gnt_o) begin
            ram_we_o = core_we_i;
        end else if (dbg_gnt_o) begin
            ram_we_o    = dbg_we_i;
            ram_addr_o  = dbg_addr_i;
            ram_wdata_o = dbg_wdata_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_dbg_q <= 1'b0;
        end else if (core_gnt_o) begin
            last_dbg_q <= 1'b0;
        end else if (dbg_gnt_o) begin
            last_dbg_q <= 1'b1;
        end
    end

    a_gnt_onehot: assert property (
        @(posedge clk) disable iff (!rst_n) !(core_gnt_o && dbg_gnt_o)
    ) else $error("both ram grants high");

endmodule

// File: verilog/data_ram.sv
`timescale 1ns/1ps

module data_ram (
    input  logic                      clk,
    input  logic                      we_i,
    input  logic [rv_pkg::MEM_AW-1:0] addr_i,
    input  logic [rv_pkg::XLEN-1:0]   wdata_i,
    output logic [rv_pkg::XLEN-1:0]   rdata_o
);
    import rv_pkg::*;

    logic [XLEN-1:0] mem [2**MEM_AW];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
        rdata_o <= mem[addr_i];   // old data on a write cycle
    end

endmodule

// File: verilog/rv_exec_top.sv
`timescale 1ns/1ps

module rv_exec_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      instr_valid_i,
    input  rv_pkg::instr_u            instr_i,
    output logic                      busy_o,
    input  logic                      dbg_req_i,
    input  logic                      dbg_mem_i,
    input  logic                      dbg_we_i,
    input  logic [rv_pkg::MEM_AW-1:0] dbg_addr_i,
    input  logic [rv_pkg::XLEN-1:0]   dbg_wdata_i,
    output logic                      dbg_ack_o,
    output logic [rv_pkg::XLEN-1:0]   dbg_rdata_o
);
    import rv_pkg::*;

    // register file side
    logic [REG_AW-1:0] rs1_addr;
    logic [REG_AW-1:0] rs2_addr;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    logic              rd_we;
    logic [REG_AW-1:0] rd_addr;
    logic [XLEN-1:0]   rd_data;
    logic [REG_AW-1:0] bus_raddr;
    logic [XLEN-1:0]   bus_data;

    // memory side
    logic              core_req;
    logic              core_we;
    logic [MEM_AW-1:0] core_addr;
    logic [XLEN-1:0]   core_wdata;
    logic              core_gnt;
    logic              dbg_mreq;
    logic              dbg_mwe;
    logic [MEM_AW-1:0] dbg_maddr;
    logic [XLEN-1:0]   dbg_mwdata;
    logic              dbg_gnt;
    logic              ram_we;
    logic [MEM_AW-1:0] ram_addr;
    logic [XLEN-1:0]   ram_wdata;
    logic [XLEN-1:0]   ram_rdata;

    reg_file u_reg_file (
        .clk         (clk),
        .rst_n       (rst_n),
        .raddr1_i    (rs1_addr),
        .raddr2_i    (rs2_addr),
        .bus_raddr_i (bus_raddr),
        .rdata1_o    (rs1_data),
        .rdata2_o    (rs2_data),
        .bus_data_o  (bus_data),
        .we_i        (rd_we),
        .waddr_i     (rd_addr),
        .wdata_i     (rd_data)
    );

    inst_exec u_inst_exec (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .busy_o        (busy_o),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .rd_we_o       (rd_we),
        .rd_addr_o     (rd_addr),
        .rd_data_o     (rd_data),
        .mem_req_o     (core_req),
        .mem_we_o      (core_we),
        .mem_addr_o    (core_addr),
        .mem_wdata_o   (core_wdata),
        .mem_gnt_i     (core_gnt),
        .mem_rdata_i   (ram_rdata)
    );

    debug_port u_debug_port (
        .clk         (clk),
        .rst_n       (rst_n),
        .dbg_req_i   (dbg_req_i),
        .dbg_mem_i   (dbg_mem_i),
        .dbg_we_i    (dbg_we_i),
        .dbg_addr_i  (dbg_addr_i),
        .dbg_wdata_i (dbg_wdata_i),
        .dbg_ack_o   (dbg_ack_o),
        .dbg_rdata_o (dbg_rdata_o),
        .reg_addr_o  (bus_raddr),
        .reg_data_i  (bus_data),
        .mem_req_o   (dbg_mreq),
        .mem_we_o    (dbg_mwe),
        .mem_addr_o  (dbg_maddr),
        .mem_wdata_o (dbg_mwdata),
        .mem_gnt_i   (dbg_gnt),
        .mem_rdata_i (ram_rdata)
    );

    mem_arbiter u_mem_arbiter (
        .clk          (clk),
        .rst_n        (rst_n),
        .core_req_i   (core_req),
        .core_we_i    (core_we),
        .core_addr_i  (core_addr),
        .core_wdata_i (core_wdata),
        .dbg_req_i    (dbg_mreq),
        .dbg_we_i     (dbg_mwe),
        .dbg_addr_i   (dbg_maddr),
        .dbg_wdata_i  (dbg_mwdata),
        .core_gnt_o   (core_gnt),
        .dbg_gnt_o    (dbg_gnt),
        .ram_we_o     (ram_we),
        .ram_addr_o   (ram_addr),
        .ram_wdata_o  (ram_wdata)
    );

    data_ram u_data_ram (
        .clk     (clk),
        .we_i    (ram_we),
        .addr_i  (ram_addr),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

endmodule

// File: tests/tb_rv_exec_top.sv
`timescale 1ns/1ps

module tb_rv_exec_top;
    import rv_pkg::*;

    logic              clk;
    logic              rst_n;
    logic              instr_valid_i;
    instr_u            instr_i;
    logic              busy_o;
    logic              dbg_req_i;
    logic              dbg_mem_i;
    logic              dbg_we_i;
    logic [MEM_AW-1:0] dbg_addr_i;
    logic [XLEN-1:0]   dbg_wdata_i;
    logic              dbg_ack_o;
    logic [XLEN-1:0]   dbg_rdata_o;

    logic [XLEN-1:0] model_regs [32];
    logic [XLEN-1:0] model_mem [256];   // only words written by the tests are valid
    int unsigned     seed_ret;

    rv_exec_top u_rv_exec_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .busy_o        (busy_o),
        .dbg_req_i     (dbg_req_i),
        .dbg_mem_i     (dbg_mem_i),
        .dbg_we_i      (dbg_we_i),
        .dbg_addr_i    (dbg_addr_i),
        .dbg_wdata_i   (dbg_wdata_i),
        .dbg_ack_o     (dbg_ack_o),
        .dbg_rdata_o   (dbg_rdata_o)
    );

    always #20 clk = ~clk;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] got);
        if (got !== exp) begin
            abort_run($sformatf("mismatch %s exp %h got %h", name, exp, got));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            abort_run($sformatf("mismatch %s exp %h got %h", name, exp, got));
        end
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #2;   // drive and sample just after the edge
    endtask

    function automatic logic [XLEN-1:0] sext12(input logic [11:0] v);
        return {{(XLEN-12){v[11]}}, v};
    endfunction

    // word index from a byte address
    function automatic logic [MEM_AW-1:0] eff_word(input logic [XLEN-1:0] base,
                                                   input logic [11:0] imm);
        logic [XLEN-1:0] a;
        a = base + sext12(imm);
        return a[MEM_AW+1:2];
    endfunction

    function automatic logic [XLEN-1:0] alu_ref(input logic [6:0] f7, input logic [2:0] f3,
                                                 input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b);
        case (f3)
            F3_ADD_SUB: return (f7 == F7_SUB) ? a - b : a + b;
            F3_XOR:     return a ^ b;
            F3_OR:      return a | b;
            default:    return a & b;
        endcase
    endfunction

    function automatic instr_u build_r(input logic [6:0] f7, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [4:0] rs2);
        instr_u ins;
        ins          = '0;
        ins.r.opcode = OP_RTYPE;
        ins.r.funct7 = f7;
        ins.r.funct3 = f3;
        ins.r.rd     = rd;
        ins.r.rs1    = rs1;
        ins.r.rs2    = rs2;
        return ins;
    endfunction

    function automatic instr_u build_i(input logic [6:0] op, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
        instr_u ins;
        ins          = '0;
        ins.i.opcode = op;
        ins.i.funct3 = f3;
        ins.i.rd     = rd;
        ins.i.rs1    = rs1;
        ins.i.imm    = imm;
        return ins;
    endfunction

    function automatic instr_u build_s(input logic [4:0] rs1, input logic [4:0] rs2,
                                       input logic [11:0] imm);
        instr_u ins;
        ins          = '0;
        ins.s.opcode = OP_STORE;
        ins.s.funct3 = F3_LW_SW;
        ins.s.rs1    = rs1;
        ins.s.rs2    = rs2;
        ins.s.imm_hi = imm[11:5];
        ins.s.imm_lo = imm[4:0];
        return ins;
    endfunction

    task automatic issue_instr(input instr_u ins, input logic is_mem);
        int n;
        instr_valid_i = 1'b1;
        instr_i       = ins;
        next_cycle;
        instr_valid_i = 1'b0;
        check_bit("busy_o", is_mem, busy_o);
        n = 0;
        while (busy_o && n < 200) begin
            next_cycle;
            n++;
        end
        if (busy_o) abort_run("timeout: busy_o stayed high after a load or store");
    endtask

    task automatic dbg_access(input logic mem, input logic we, input logic [MEM_AW-1:0] addr,
                              input logic [XLEN-1:0] wdata, output logic [XLEN-1:0] rdata);
        int n;
        dbg_req_i   = 1'b1;
        dbg_mem_i   = mem;
        dbg_we_i    = we;
        dbg_addr_i  = addr;
        dbg_wdata_i = wdata;
        next_cycle;
        dbg_req_i = 1'b0;
        n = 0;
        while (!dbg_ack_o && n < 200) begin
            next_cycle;
            n++;
        end
        if (!dbg_ack_o) abort_run("timeout: no acknowledge on a debug access");
        rdata = dbg_rdata_o;
        next_cycle;
        check_bit("dbg_ack_o", 1'b0, dbg_ack_o);   // single pulse
    endtask

    task automatic do_addi(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        logic [XLEN-1:0] res;
        res = model_regs[rs1] + sext12(imm);
        issue_instr(build_i(OP_ITYPE, F3_ADD_SUB, rd, rs1, imm), 1'b0);
        if (rd != 5'd0) model_regs[rd] = res;
    endtask

    task automatic do_rtype(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rd,
                            input logic [4:0] rs1, input logic [4:0] rs2);
        logic [XLEN-1:0] res;
        res = alu_ref(f7, f3, model_regs[rs1], model_regs[rs2]);
        issue_instr(build_r(f7, f3, rd, rs1, rs2), 1'b0);
        if (rd != 5'd0) model_regs[rd] = res;
    endtask

    task automatic do_sw(input logic [4:0] rs1, input logic [4:0] rs2, input logic [11:0] imm);
        model_mem[eff_word(model_regs[rs1], imm)] = model_regs[rs2];
        issue_instr(build_s(rs1, rs2, imm), 1'b1);
    endtask

    task automatic do_lw(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        logic [MEM_AW-1:0] w;
        w = eff_word(model_regs[rs1], imm);
        issue_instr(build_i(OP_LOAD, F3_LW_SW, rd, rs1, imm), 1'b1);
        if (rd != 5'd0) model_regs[rd] = model_mem[w];
    endtask

    task automatic check_all_regs;
        logic [XLEN-1:0] val;
        for (int i = 0; i < 32; i++) begin
            dbg_access(1'b0, 1'b0, 8'(i), '0, val);
            check_word($sformatf("dbg_rdata_o x%0d", i), model_regs[i], val);
        end
    endtask

    // imm that reaches word w from the 0x400 base held in x20
    function automatic logic [11:0] imm_for(input logic [MEM_AW-1:0] w);
        int off;
        off = int'(w) * 4 - 1024;
        return 12'(off);
    endfunction

    task automatic test_reset_state;
        check_bit("busy_o", 1'b0, busy_o);
        check_bit("dbg_ack_o", 1'b0, dbg_ack_o);
        check_all_regs;
    endtask

    task automatic test_alu_ops;
        logic [6:0] f7;
        logic [2:0] f3;
        for (int r = 1; r < 32; r++) begin
            do_addi(5'(r), 5'd0, 12'($urandom));
        end
        for (int k = 0; k < 40; k++) begin
            f7 = 7'd0;
            case ($urandom % 5)
                0:       f3 = F3_ADD_SUB;
                1: begin
                    f3 = F3_ADD_SUB;
                    f7 = F7_SUB;
                end
                2:       f3 = F3_AND;
                3:       f3 = F3_OR;
                default: f3 = F3_XOR;
            endcase
            do_rtype(f7, f3, 5'(1 + $urandom % 31), 5'($urandom), 5'($urandom));
        end
        for (int k = 0; k < 8; k++) begin
            do_addi(5'(1 + $urandom % 31), 5'($urandom), 12'($urandom));
        end
        check_all_regs;
    endtask

    task automatic test_x0_rules;
        do_addi(5'd0, 5'd5, 12'h123);
        do_rtype(7'd0, F3_ADD_SUB, 5'd0, 5'd6, 5'd7);
        do_rtype(7'd0, F3_ADD_SUB, 5'd9, 5'd0, 5'd10);   // x9 = x10
        do_rtype(7'd0, F3_OR, 5'd11, 5'd12, 5'd0);
        do_rtype(F7_SUB, F3_ADD_SUB, 5'd13, 5'd14, 5'd0);
        do_rtype(7'd0, F3_XOR, 5'd15, 5'd0, 5'd16);
        check_all_regs;
    endtask

    task automatic test_load_store;
        logic [MEM_AW-1:0] w;
        logic [XLEN-1:0]   d;
        logic [XLEN-1:0]   val;
        logic [4:0]        rd;
        do_addi(5'd20, 5'd0, 12'h400);   // base, negative offsets below
        for (int k = 0; k < 8; k++) begin
            w = 8'($urandom);
            do_sw(5'd20, 5'(1 + $urandom % 19), imm_for(w));
            dbg_access(1'b1, 1'b0, w, '0, val);
            check_word($sformatf("dbg_rdata_o mem[%0d]", w), model_mem[w], val);
        end
        for (int k = 0; k < 8; k++) begin
            w  = 8'($urandom);
            d  = $urandom;
            rd = 5'(21 + $urandom % 11);
            dbg_access(1'b1, 1'b1, w, d, val);
            model_mem[w] = d;
            do_lw(rd, 5'd20, imm_for(w));
            dbg_access(1'b0, 1'b0, 8'(rd), '0, val);
            check_word($sformatf("dbg_rdata_o x%0d", rd), model_regs[rd], val);
        end
    endtask

    // load and debug memory read issued on the same edge
    task automatic test_contention(input int pass);
        logic [MEM_AW-1:0] wa;
        logic [MEM_AW-1:0] wb;
        logic [XLEN-1:0]   val;
        logic [XLEN-1:0]   dbg_val;
        logic [4:0]        rd;
        int                acks;
        int                n;
        wa = 8'($urandom);
        wb = wa ^ 8'h01;
        rd = 5'(21 + $urandom % 11);
        dbg_access(1'b1, 1'b1, wa, $urandom, val);
        model_mem[wa] = dbg_wdata_i;
        dbg_access(1'b1, 1'b1, wb, $urandom, val);
        model_mem[wb] = dbg_wdata_i;
        if (pass == 1) do_sw(5'd20, 5'd21, imm_for(wa ^ 8'h80));   // core won last
        instr_valid_i = 1'b1;
        instr_i       = build_i(OP_LOAD, F3_LW_SW, rd, 5'd20, imm_for(wa));
        dbg_req_i     = 1'b1;
        dbg_mem_i     = 1'b1;
        dbg_we_i      = 1'b0;
        dbg_addr_i    = wb;
        next_cycle;
        instr_valid_i = 1'b0;
        dbg_req_i     = 1'b0;
        check_bit("busy_o", 1'b1, busy_o);
        acks    = 0;
        dbg_val = '0;
        n       = 0;
        while ((busy_o || acks == 0) && n < 200) begin
            if (dbg_ack_o) begin
                acks++;
                dbg_val = dbg_rdata_o;
            end
            next_cycle;
            n++;
        end
        if (n >= 200) abort_run("timeout: contended load or debug read did not finish");
        for (int k = 0; k < 4; k++) begin
            if (dbg_ack_o) acks++;
            next_cycle;
        end
        check_word("dbg_ack_o pulse count", 32'd1, 32'(acks));
        check_word($sformatf("dbg_rdata_o mem[%0d]", wb), model_mem[wb], dbg_val);
        model_regs[rd] = model_mem[wa];
        dbg_access(1'b0, 1'b0, 8'(rd), '0, val);
        check_word($sformatf("dbg_rdata_o x%0d", rd), model_regs[rd], val);
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        dbg_req_i     = 1'b0;
        dbg_mem_i     = 1'b0;
        dbg_we_i      = 1'b0;
        dbg_addr_i    = '0;
        dbg_wdata_i   = '0;
        seed_ret      = $urandom(32'h5f3e_9666);
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        next_cycle;

        test_reset_state;
        test_alu_ops;
        test_x0_rules;
        test_load_store;
        test_contention(0);
        test_contention(1);

        $display("** PASS **");
        $finish;
    end

endmodule

// File: sources.f
verilog/rv_pkg.sv
verilog/reg_file.sv
verilog/inst_exec.sv
verilog/debug_port.sv
verilog/mem_arbiter.sv
verilog/data_ram.sv
verilog/rv_exec_top.sv
tests/tb_rv_exec_top.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_rv_exec_top -Mdir obj_dir -o sim_tb -f sources.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q '^\*\* PASS \*\*$' "$LOG" && [ "$run_status" -eq 0 ]; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed (exit status $run_status)"
exit 1
